/* common/soc_pkg.sv */
package soc_pkg;

    // ********************
    // Sizes and clock
    // ********************

    localparam int xlen      = 32;
    localparam int fmax_mhz  = 27;                   // Clock cycles per microsecond.
    localparam int tick_w    = $clog2(fmax_mhz);
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);    // Word index width.

    // ********************
    // Address map
    // ********************

    localparam logic [xlen-1:0] mmio_base = 32'hF000_0000;  // Everything above is registers.

    localparam logic [xlen-1:0] mtime_lo_ofs    = 32'h0000_0000;
    localparam logic [xlen-1:0] mtime_hi_ofs    = 32'h0000_0004;
    localparam logic [xlen-1:0] mtimecmp_lo_ofs = 32'h0000_0008;
    localparam logic [xlen-1:0] mtimecmp_hi_ofs = 32'h0000_000C;
    localparam logic [xlen-1:0] exit_ofs        = 32'h0000_0010;
    localparam logic [xlen-1:0] cycle_lo_ofs    = 32'h0000_0014;
    localparam logic [xlen-1:0] cycle_hi_ofs    = 32'h0000_0018;

    // ********************
    // Bus types
    // ********************

    typedef logic [63:0] u64_t;

    // Request, held by the requester until accepted.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic            wen;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    // One response per accepted request; writes get an acknowledge.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] rdata;
    } mem_resp_t;

endpackage

/* dv/soc_top_tb.sv */
`timescale 1ns/1ns

module soc_top_tb import soc_pkg::*; ();

    localparam int         max_cycles = 5000;     // The tests need about 2400.
    localparam int         n_mem_ops  = 300;
    localparam int         irq_limit  = 3 * fmax_mhz + 2;
    localparam logic [1:0] k_mem      = 2'd0;
    localparam logic [1:0] k_cycle    = 2'd1;
    localparam logic [1:0] k_mtime    = 2'd2;
    localparam logic [1:0] k_other    = 2'd3;

    logic      clk_in = 1'b0;
    logic      rst;
    mem_req_t  ireq;
    mem_req_t  dreq;
    logic      iready;
    logic      dready;
    mem_resp_t iresp;
    mem_resp_t dresp;
    logic      timer_irq;
    logic      exited;
    logic [5:0] led;

    int              seed   = 32'h55050452;
    int              errors = 0;
    int              cyc_cnt = 0;
    logic [xlen-1:0] ref_mem [mem_words] = '{default: '0};
    logic [xlen-1:0] written [$];

    logic            d_acc;
    logic            i_acc;
    logic            exit_acc;
    logic            clr_acc;
    logic            d_pend = 1'b0;
    logic            i_pend = 1'b0;
    logic [1:0]      d_kind = k_other;
    logic [31:0]     d_exp = '0;
    logic [31:0]     i_exp = '0;
    logic [31:0]     d_acc_cyc = '0;
    logic [31:0]     cyc_ref = '0;
    logic [31:0]     cyc_ref_acc = '0;
    logic            cyc_have = 1'b0;
    logic [31:0]     mt_ref = '0;
    logic [31:0]     mt_ref_acc = '0;
    logic            mt_have = 1'b0;
    logic [31:0]     cyc_expect;
    logic [31:0]     mt_delta;
    logic [31:0]     mt_steps;
    logic [31:0]     mt_steps_up;
    logic            irq_armed = 1'b0;
    logic [31:0]     irq_target = '0;
    int              irq_wait = 0;
    logic            clr_d1 = 1'b0;
    logic            clr_d2 = 1'b0;
    logic            exit_d1 = 1'b0;
    logic            exit_any = 1'b0;
    logic [31:0]     exit_val = '0;

    soc_top UUT (
        .clk_in    (clk_in),
        .rst       (rst),
        .ireq      (ireq),
        .iready    (iready),
        .iresp     (iresp),
        .dreq      (dreq),
        .dready    (dready),
        .dresp     (dresp),
        .timer_irq (timer_irq),
        .exited    (exited),
        .led       (led)
    );

    always #5 clk_in = ~clk_in;

    // ********************
    // Reference model
    // ********************

    assign d_acc      = dreq.valid && dready;
    assign i_acc      = ireq.valid && iready;
    assign exit_acc   = d_acc && dreq.wen && (dreq.addr == mmio_base + exit_ofs);
    assign clr_acc    = d_acc && dreq.wen && (dreq.addr == mmio_base + mtimecmp_hi_ofs)
                        && (dreq.wdata == 32'hFFFF_FFFF);
    assign cyc_expect = cyc_ref + (d_acc_cyc - cyc_ref_acc);
    assign mt_delta   = dresp.rdata - mt_ref;
    assign mt_steps   = (d_acc_cyc - mt_ref_acc) / 32'(fmax_mhz);
    assign mt_steps_up = (d_acc_cyc - mt_ref_acc + 32'(fmax_mhz - 1)) / 32'(fmax_mhz);

    always @(posedge clk_in) begin
        d_pend   <= d_acc;
        i_pend   <= i_acc;
        clr_d1   <= clr_acc;
        clr_d2   <= clr_d1;
        exit_d1  <= exit_acc;
        exit_any <= exit_any || exit_acc;
        if (exit_acc) begin
            exit_val <= dreq.wdata;
        end
        if (i_acc) begin
            i_exp <= ref_mem[ireq.addr[mem_aw+1:2]];
        end
        if (d_acc) begin
            d_acc_cyc <= cyc_cnt;
            d_exp     <= ref_mem[dreq.addr[mem_aw+1:2]];
            if (dreq.addr < mmio_base) begin
                d_kind <= dreq.wen ? k_other : k_mem;
                if (dreq.wen) begin
                    ref_mem[dreq.addr[mem_aw+1:2]] <= dreq.wdata;
                end
            end else if (!dreq.wen && dreq.addr == mmio_base + cycle_lo_ofs) begin
                d_kind <= k_cycle;
            end else if (!dreq.wen && dreq.addr == mmio_base + mtime_lo_ofs) begin
                d_kind <= k_mtime;
            end else begin
                d_kind <= k_other;
            end
        end
        // Each counter read becomes the reference for the next one.
        if (dresp.valid && d_kind == k_cycle) begin
            cyc_ref     <= dresp.rdata;
            cyc_ref_acc <= d_acc_cyc;
            cyc_have    <= 1'b1;
        end
        if (dresp.valid && d_kind == k_mtime) begin
            mt_ref     <= dresp.rdata;
            mt_ref_acc <= d_acc_cyc;
            mt_have    <= 1'b1;
        end
        if (!irq_armed) begin
            irq_wait <= 0;
        end else if (!timer_irq && irq_wait <= irq_limit + 1) begin
            irq_wait <= irq_wait + 1;
        end
    end

    always @(posedge clk_in) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= max_cycles) begin
            $display("Timeout after %0d cycles with %0d errors", max_cycles, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ********************
    // Checks
    // ********************

    reset_state_chk: assert property (@(posedge clk_in) $fell(rst) |->
            !iresp.valid && !dresp.valid && !timer_irq && !exited && led == 6'h3F)
        else begin
            errors++;
            $display("Mismatch at %0t: %s expected %s got %b/%b/%b/%b/%h", $time,
                "iresp.valid/dresp.valid/timer_irq/exited/led", "0/0/0/0/3f",
                $sampled(iresp.valid), $sampled(dresp.valid), $sampled(timer_irq),
                $sampled(exited), $sampled(led));
        end

    dresp_timing_chk: assert property (@(posedge clk_in) disable iff (rst)
            dresp.valid == d_pend)
        else begin
            errors++;
            $display("Mismatch at %0t: dresp.valid expected %b got %b",
                $time, $sampled(d_pend), $sampled(dresp.valid));
        end

    iresp_timing_chk: assert property (@(posedge clk_in) disable iff (rst)
            iresp.valid == i_pend)
        else begin
            errors++;
            $display("Mismatch at %0t: iresp.valid expected %b got %b",
                $time, $sampled(i_pend), $sampled(iresp.valid));
        end

    dmem_data_chk: assert property (@(posedge clk_in) disable iff (rst)
            dresp.valid && d_kind == k_mem |-> dresp.rdata == d_exp)
        else begin
            errors++;
            $display("Mismatch at %0t: dresp.rdata expected %h got %h",
                $time, $sampled(d_exp), $sampled(dresp.rdata));
        end

    fetch_data_chk: assert property (@(posedge clk_in) disable iff (rst)
            iresp.valid |-> iresp.rdata == i_exp)
        else begin
            errors++;
            $display("Mismatch at %0t: iresp.rdata expected %h got %h",
                $time, $sampled(i_exp), $sampled(iresp.rdata));
        end

    priority_chk: assert property (@(posedge clk_in) disable iff (rst)
            dreq.valid && dreq.addr < mmio_base && ireq.valid |-> !iready && dready)
        else begin
            errors++;
            $display("Mismatch at %0t: iready/dready expected 0/1 got %b/%b",
                $time, $sampled(iready), $sampled(dready));
        end

    cycle_chk: assert property (@(posedge clk_in) disable iff (rst)
            dresp.valid && d_kind == k_cycle && cyc_have |-> dresp.rdata == cyc_expect)
        else begin
            errors++;
            $display("Mismatch at %0t: cycle_lo expected %h got %h",
                $time, $sampled(cyc_expect), $sampled(dresp.rdata));
        end

    mtime_chk: assert property (@(posedge clk_in) disable iff (rst)
            dresp.valid && d_kind == k_mtime && mt_have |->
            (mt_delta == mt_steps || mt_delta == mt_steps_up))
        else begin
            errors++;
            $display("Mismatch at %0t: mtime_lo step expected %0d or %0d got %0d",
                $time, $sampled(mt_steps), $sampled(mt_steps_up), $sampled(mt_delta));
        end

    irq_early_chk: assert property (@(posedge clk_in) disable iff (rst)
            irq_armed && dresp.valid && d_kind == k_mtime && dresp.rdata < irq_target
            |-> !timer_irq)
        else begin
            errors++;
            $display("Mismatch at %0t: timer_irq expected 0 got 1", $time);
        end

    irq_late_chk: assert property (@(posedge clk_in) disable iff (rst)
            irq_wait != irq_limit + 1)
        else begin
            errors++;
            $display("timer_irq did not rise within %0d cycles at %0t", irq_limit, $time);
        end

    irq_clear_chk: assert property (@(posedge clk_in) disable iff (rst)
            clr_d2 |-> !timer_irq)
        else begin
            errors++;
            $display("Mismatch at %0t: timer_irq expected 0 got 1", $time);
        end

    exit_chk: assert property (@(posedge clk_in) disable iff (rst)
            exit_d1 |-> exited && led == ~exit_val[5:0])
        else begin
            errors++;
            $display("Mismatch at %0t: exited/led expected 1/%h got %b/%h", $time,
                ~$sampled(exit_val[5:0]), $sampled(exited), $sampled(led));
        end

    exit_early_chk: assert property (@(posedge clk_in) disable iff (rst)
            !exit_any |-> !exited)
        else begin
            errors++;
            $display("Mismatch at %0t: exited expected 0 got 1 with no exit write", $time);
        end

    // ********************
    // Stimulus
    // ********************

    function automatic logic [31:0] rand_mem_addr();
        return $random(seed) & 32'h0FFF_FFFC;    // Word aligned, below mmio_base.
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    // Holds the request until accepted, returns the response data.
    task automatic data_access(input logic [31:0] addr, input logic wen,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk_in);
        dreq.valid = 1'b1;
        dreq.addr  = addr;
        dreq.wen   = wen;
        dreq.wdata = wdata;
        do begin
            @(negedge clk_in);
        end while (!d_pend);
        rdata      = dresp.rdata;
        dreq.valid = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] addr);
        @(negedge clk_in);
        ireq.valid = 1'b1;
        ireq.addr  = addr;
        ireq.wen   = 1'b0;
        ireq.wdata = '0;
        do begin
            @(negedge clk_in);
        end while (!i_pend);
        ireq.valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] t0;
        logic        wen;
        ireq = '0;
        dreq = '0;
        rst  = 1'b1;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;

        for (int n = 0; n < n_mem_ops; n++) begin
            addr = rand_mem_addr();
            wen  = 1'($random(seed));
            if (wen) begin
                written.push_back(addr);
            end
            data_access(addr, wen, $random(seed), data);
        end

        // Fetch written words, then race fetches against data accesses.
        for (int n = 0; n < 40; n++) begin
            fetch(written[($random(seed) & 32'h7FFF_FFFF) % written.size()]);
        end
        for (int n = 0; n < 20; n++) begin
            addr = written[($random(seed) & 32'h7FFF_FFFF) % written.size()];
            fork
                data_access(addr, 1'(n), $random(seed), data);
                fetch(addr);
            join
        end

        for (int n = 0; n < 6; n++) begin
            data_access(mmio_base + cycle_lo_ofs, 1'b0, '0, data);
            wait_cycles($random(seed) & 127);
        end
        for (int n = 0; n < 8; n++) begin
            data_access(mmio_base + mtime_lo_ofs, 1'b0, '0, data);
            wait_cycles($random(seed) & 255);
        end

        data_access(mmio_base + mtime_lo_ofs, 1'b0, '0, t0);
        data_access(mmio_base + mtimecmp_lo_ofs, 1'b1, t0 + 32'd2, data);
        data_access(mmio_base + mtimecmp_hi_ofs, 1'b1, '0, data);
        irq_target = t0 + 32'd2;
        irq_armed  = 1'b1;
        while (!timer_irq) begin
            data_access(mmio_base + mtime_lo_ofs, 1'b0, '0, data);
        end
        irq_armed = 1'b0;
        data_access(mmio_base + mtimecmp_hi_ofs, 1'b1, 32'hFFFF_FFFF, data);
        wait_cycles(3);

        data_access(mmio_base + exit_ofs, 1'b1, $random(seed), data);
        wait_cycles(2);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* logic/mmio_cntr.sv */
`timescale 1ns/1ns

module mmio_cntr import soc_pkg::*; (
    input  logic        clk_in,
    input  logic        rst,

    // Data accesses from the core side.
    input  mem_req_t    dreq,
    output logic        dready,
    output mem_resp_t   dresp,

    // Forwarded memory accesses.
    output mem_req_t    bus_req,
    input  logic        bus_ready,
    input  mem_resp_t   bus_resp,

    // Timer registers.
    input  u64_t        cycle,
    input  u64_t        mtime,
    input  u64_t        mtimecmp,
    output logic        cmp_wen,
    output logic        cmp_hi,
    output logic [31:0] cmp_wdata,

    output logic        exited,
    output logic [31:0] gp
);

    logic            is_reg;
    logic            reg_acc;
    logic [xlen-1:0] ofs;
    logic [xlen-1:0] rd_val;
    logic            exit_wen;
    logic            reg_resp_valid;
    logic [xlen-1:0] reg_rdata;

    // ********************
    // Decode
    // ********************

    assign is_reg  = (dreq.addr >= mmio_base);
    assign ofs     = dreq.addr - mmio_base;
    assign dready  = is_reg ? 1'b1 : bus_ready;    // Registers never stall.
    assign reg_acc = dreq.valid && is_reg;

    always_comb begin
        bus_req       = dreq;
        bus_req.valid = dreq.valid && !is_reg;
    end

    assign cmp_hi    = (ofs == mtimecmp_hi_ofs);
    assign cmp_wen   = reg_acc && dreq.wen && (cmp_hi || ofs == mtimecmp_lo_ofs);
    assign cmp_wdata = dreq.wdata;
    assign exit_wen  = reg_acc && dreq.wen && (ofs == exit_ofs);

    // ********************
    // Register read
    // ********************

    always_comb begin
        case (ofs)
            mtime_lo_ofs:    rd_val = mtime[31:0];
            mtime_hi_ofs:    rd_val = mtime[63:32];
            mtimecmp_lo_ofs: rd_val = mtimecmp[31:0];
            mtimecmp_hi_ofs: rd_val = mtimecmp[63:32];
            exit_ofs:        rd_val = gp;
            cycle_lo_ofs:    rd_val = cycle[31:0];
            cycle_hi_ofs:    rd_val = cycle[63:32];
            default:         rd_val = '0;                 // Unmapped.
        endcase
    end

    always_ff @(posedge clk_in) begin
        reg_rdata <= rd_val;                              // Sampled at acceptance.
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            reg_resp_valid <= 1'b0;
            exited         <= 1'b0;
            gp             <= '0;
        end else begin
            reg_resp_valid <= reg_acc;
            if (exit_wen) begin
                exited <= 1'b1;                           // Sticky until reset.
                gp     <= dreq.wdata;
            end
        end
    end

    always_comb begin
        dresp.valid = reg_resp_valid || bus_resp.valid;
        dresp.rdata = reg_resp_valid ? reg_rdata : bus_resp.rdata;
    end

    // Bus responses must also arrive one cycle after acceptance.
    assert property (@(posedge clk_in) disable iff (rst)
        !(reg_resp_valid && bus_resp.valid))
        else $error("mmio_cntr: register and bus responses overlap");

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ns

module soc_top import soc_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,

    // Instruction fetch port.
    input  mem_req_t  ireq,
    output logic      iready,
    output mem_resp_t iresp,

    // Data access port.
    input  mem_req_t  dreq,
    output logic      dready,
    output mem_resp_t dresp,

    output logic      timer_irq,
    output logic      exited,
    output logic [5:0] led
);

    mem_req_t    bus_req;
    logic        bus_ready;
    mem_resp_t   bus_resp;

    mem_req_t    mem_req;
    logic        mem_ready;
    mem_resp_t   mem_resp;

    u64_t        cycle;
    u64_t        mtime;
    u64_t        mtimecmp;
    logic        cmp_wen;
    logic        cmp_hi;
    logic [31:0] cmp_wdata;
    logic [31:0] gp;

    assign led = ~gp[5:0];    // LEDs are active low.

    // ********************
    // Memory side
    // ********************

    memory u_memory (
        .clk_in (clk_in),
        .rst    (rst),
        .req    (mem_req),
        .ready  (mem_ready),
        .resp   (mem_resp)
    );

    mem_bus_arbiter u_arbiter (
        .clk_in    (clk_in),
        .rst       (rst),
        .ireq      (ireq),
        .iready    (iready),
        .iresp     (iresp),
        .dreq      (bus_req),
        .dready    (bus_ready),
        .dresp     (bus_resp),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_resp  (mem_resp)
    );

    // ********************
    // Registers
    // ********************

    timer_unit u_timer (
        .clk_in    (clk_in),
        .rst       (rst),
        .cmp_wen   (cmp_wen),
        .cmp_hi    (cmp_hi),
        .cmp_wdata (cmp_wdata),
        .cycle     (cycle),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

    mmio_cntr u_mmio (
        .clk_in    (clk_in),
        .rst       (rst),
        .dreq      (dreq),
        .dready    (dready),
        .dresp     (dresp),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_resp  (bus_resp),
        .cycle     (cycle),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .cmp_wen   (cmp_wen),
        .cmp_hi    (cmp_hi),
        .cmp_wdata (cmp_wdata),
        .exited    (exited),
        .gp        (gp)
    );

endmodule

/* logic/timer_unit.sv */
`timescale 1ns/1ns

module timer_unit import soc_pkg::*; (
    input  logic        clk_in,
    input  logic        rst,
    input  logic        cmp_wen,
    input  logic        cmp_hi,
    input  logic [31:0] cmp_wdata,
    output u64_t        cycle,
    output u64_t        mtime,
    output u64_t        mtimecmp,
    output logic        timer_irq
);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;

    assign tick = (tick_cnt == tick_w'(fmax_mhz - 1));   // One microsecond passed.

    // ********************
    // Counters
    // ********************

    always_ff @(posedge clk_in) begin
        if (rst) begin
            cycle    <= '0;
            mtime    <= '0;
            tick_cnt <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            if (tick) begin
                mtime    <= mtime + 64'd1;
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // ********************
    // Compare and interrupt
    // ********************

    always_ff @(posedge clk_in) begin
        if (rst) begin
            mtimecmp  <= '1;                          // No interrupt until programmed.
            timer_irq <= 1'b0;
        end else begin
            if (cmp_wen && cmp_hi) begin
                mtimecmp[63:32] <= cmp_wdata;
            end else if (cmp_wen) begin
                mtimecmp[31:0] <= cmp_wdata;
            end
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

/* membus/mem_bus_arbiter.sv */
`timescale 1ns/1ns

module mem_bus_arbiter import soc_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,

    // Instruction fetch port.
    input  mem_req_t  ireq,
    output logic      iready,
    output mem_resp_t iresp,

    // Data port, higher priority.
    input  mem_req_t  dreq,
    output logic      dready,
    output mem_resp_t dresp,

    // Toward memory.
    output mem_req_t  mem_req,
    input  logic      mem_ready,
    input  mem_resp_t mem_resp
);

    logic sel_d;
    logic owner_d;

    // ********************
    // Request select
    // ********************

    assign sel_d  = dreq.valid;                  // Data wins whenever it asks.
    assign dready = mem_ready;
    assign iready = mem_ready && !sel_d;         // Fetch stalls behind data.

    always_comb begin
        if (sel_d) begin
            mem_req = dreq;
        end else begin
            mem_req = ireq;
        end
    end

    // ********************
    // Response steering
    // ********************

    always_ff @(posedge clk_in) begin
        if (rst) begin
            owner_d <= 1'b0;
        end else begin
            owner_d <= sel_d;                    // Owner of the response due next cycle.
        end
    end

    always_comb begin
        dresp.valid = mem_resp.valid && owner_d;
        dresp.rdata = mem_resp.rdata;
        iresp.valid = mem_resp.valid && !owner_d;
        iresp.rdata = mem_resp.rdata;
    end

    assert property (@(posedge clk_in) disable iff (rst)
        !(iresp.valid && dresp.valid))
        else $error("mem_bus_arbiter: both ports got a response in one cycle");

    // A fetch response must belong to a fetch accepted in the previous cycle.
    assert property (@(posedge clk_in) disable iff (rst)
        iresp.valid |-> $past(ireq.valid && iready))
        else $error("mem_bus_arbiter: fetch response routed without a fetch");

endmodule

/* membus/memory.sv */
`timescale 1ns/1ns

module memory import soc_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  mem_req_t  req,
    output logic      ready,
    output mem_resp_t resp
);

    logic [xlen-1:0]   mem [mem_words] = '{default: '0};
    logic [mem_aw-1:0] widx;
    logic              accept;
    logic              resp_valid;
    logic [xlen-1:0]   resp_rdata;

    assign ready  = 1'b1;                   // Never stalls.
    assign widx   = req.addr[mem_aw+1:2];   // Word address.
    assign accept = req.valid && ready;

    // ********************
    // Array and read port
    // ********************

    always_ff @(posedge clk_in) begin
        if (accept && req.wen) begin
            mem[widx] <= req.wdata;
        end
        resp_rdata <= mem[widx];            // Old word on a write, ignored by the owner.
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;           // One response per accepted request.
        end
    end

    always_comb begin
        resp.valid = resp_valid;
        resp.rdata = resp_rdata;
    end

    // No response without an accepted request one cycle earlier.
    assert property (@(posedge clk_in) disable iff (rst)
        resp.valid |-> $past(req.valid && ready))
        else $error("memory: response without an accepted request");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the soc_top testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f soc_top.f \
    --top-module soc_top_tb \
    -o soc_top_tb_sim

sim_out="$(./obj_dir/soc_top_tb_sim)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

/* soc_top.f */
common/soc_pkg.sv
membus/memory.sv
membus/mem_bus_arbiter.sv
logic/timer_unit.sv
logic/mmio_cntr.sv
logic/soc_top.sv
dv/soc_top_tb.sv
